//--- sim.f
icache_pkg.sv
icache_data_ram.sv
icache_tag_array.sv
icache_controller.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

//--- tb_icache.sv
// icache testbench, clock and reset, fetch and maintenance stimulus, checking assertions, timeout
`timescale 1ns/1ns
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int    SET_COUNT = 64;
    localparam int    OFFSET_W  = $clog2(LINE_WORDS) + 2;
    localparam int    INDEX_W   = $clog2(SET_COUNT);
    localparam word_t MEM_KEY   = 32'h5a5a5a5a;

    // sets 1 to 5, the last two share set 5
    localparam addr_t LINE_A  = 32'h0000_1040;
    localparam addr_t UC_ADDR = 32'h2000_0124;
    localparam addr_t LINE_B  = 32'h0000_2080;
    localparam addr_t LINE_C  = 32'h0000_30c0;
    localparam addr_t ALIAS_C = 32'h0000_70c0;
    localparam addr_t LINE_E  = 32'h0001_0140;
    localparam addr_t LINE_F  = 32'h0002_0140;

    logic     aclk;
    logic     aresetn;
    cpu_req_t cpu_req;
    logic     bus_stall;
    logic     bus_streq;
    word_t    bus_rdata;
    cop_req_t cop;
    axi_ar_t  ar;
    logic     arvalid;
    logic     arready;
    axi_r_t   r;
    logic     rvalid;

    axi_ar_t exp_ar;
    logic    exp_miss;
    logic    fetch_start;
    int      exp_hs_count;
    int      ar_hs_count;
    int      fetch_count;
    int      cycle_count;
    int      data_errors;
    int      ar_errors;
    int      miss_errors;

    icache_top #(
        .SET_COUNT (SET_COUNT)
    ) i_icache_top (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cpu_req   (cpu_req),
        .bus_stall (bus_stall),
        .bus_streq (bus_streq),
        .bus_rdata (bus_rdata),
        .cop       (cop),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid)
    );

    tb_axi_mem #(
        .DATA_KEY (MEM_KEY)
    ) i_tb_axi_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ar_hs_count <= 0;
        end else if (arvalid && arready) begin
            ar_hs_count <= ar_hs_count + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge aclk) $rose(aresetn) |-> !arvalid && !bus_streq)
        else begin
            ar_errors++;
            $display("ERROR %0t arvalid %b bus_streq %b expected 0 0", $time,
                     $sampled(arvalid), $sampled(bus_streq));
        end

    a_ar_held: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            ar_errors++;
            $display("read address changed or arvalid dropped before handshake at %0t", $time);
        end

    a_ar_value: assert property (@(posedge aclk) disable iff (!aresetn) arvalid |-> ar == exp_ar)
        else begin
            ar_errors++;
            $display("ERROR %0t ar got id %0d addr %h len %0d expected id %0d addr %h len %0d",
                     $time, $sampled(ar.id), $sampled(ar.addr), $sampled(ar.len),
                     exp_ar.id, exp_ar.addr, exp_ar.len);
        end

    // exactly one read per miss, none for hits
    a_ar_count: assert property (@(posedge aclk) disable iff (!aresetn)
        cpu_req.en && !bus_streq |-> ar_hs_count == exp_hs_count)
        else begin
            ar_errors++;
            $display("ERROR %0t ar handshake count got %0d expected %0d", $time,
                     $sampled(ar_hs_count), $sampled(exp_hs_count));
        end

    a_miss: assert property (@(posedge aclk) disable iff (!aresetn)
        fetch_start |-> bus_streq == exp_miss)
        else begin
            miss_errors++;
            $display("ERROR %0t bus_streq got %b expected %b", $time,
                     $sampled(bus_streq), $sampled(exp_miss));
        end

    a_data: assert property (@(posedge aclk) disable iff (!aresetn)
        cpu_req.en && !bus_streq |-> bus_rdata == (cpu_req.addr ^ MEM_KEY))
        else begin
            data_errors++;
            $display("ERROR %0t bus_rdata got %h expected %h", $time,
                     $sampled(bus_rdata), $sampled(cpu_req.addr) ^ MEM_KEY);
        end

    function automatic addr_t line_base(input addr_t addr);
        return addr & ~addr_t'(LINE_WORDS * 4 - 1);
    endfunction

    function automatic word_t tag_of(input addr_t addr);
        return word_t'(addr >> (INDEX_W + OFFSET_W));
    endfunction

    task automatic fetch(input addr_t addr, input logic cached, input logic stall,
                         input logic miss);
        @(negedge aclk);
        cop            = '0;
        bus_stall      = stall;
        cpu_req.en     = 1'b1;
        cpu_req.addr   = addr;
        cpu_req.cached = cached;
        exp_miss       = miss;
        exp_hs_count   = ar_hs_count + (miss ? 1 : 0);
        if (miss) begin
            exp_ar.id   = cached ? FILL_ID : UNCACHED_ID;
            exp_ar.addr = cached ? line_base(addr) : addr;
            exp_ar.len  = cached ? axi_len_t'(LINE_WORDS - 1) : axi_len_t'(0);
        end
        fetch_count++;
        fetch_start = 1'b1;
        #1;
        // wait in the middle of the cycle until the word is available
        while (bus_streq) begin
            @(posedge aclk);
            fetch_start = 1'b0;
            #1;
        end
        @(posedge aclk);
        fetch_start = 1'b0;
    endtask

    task automatic read_line(input addr_t base);
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(base + addr_t'(w * 4), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic fill_line(input addr_t addr);
        fetch(addr, 1'b1, 1'b0, 1'b1);
        read_line(line_base(addr));
    endtask

    task automatic maintain(input cache_op_e op, input addr_t addr, input logic valid);
        @(negedge aclk);
        cpu_req.en = 1'b0;
        bus_stall  = 1'b0;
        cop.en     = 1'b1;
        cop.op     = op;
        cop.addr   = addr;
        cop.tag    = tag_of(addr);
        cop.valid  = valid;
        @(negedge aclk);
        cop.en = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        @(negedge aclk);
        cpu_req.en = 1'b0;
        bus_stall  = 1'b0;
        cop        = '0;
        repeat (n) @(posedge aclk);
    endtask

    task automatic report_counts();
        $display("errors: data %0d, ar %0d, miss %0d", data_errors, ar_errors, miss_errors);
    endtask

    initial begin
        aresetn      = 1'b0;
        cpu_req      = '0;
        bus_stall    = 1'b0;
        cop          = '0;
        exp_ar       = '0;
        exp_miss     = 1'b0;
        fetch_start  = 1'b0;
        exp_hs_count = 0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        idle_cycles(3);
        fill_line(LINE_A);
        // word held under stall, released, then missed again
        fetch(UC_ADDR, 1'b0, 1'b1, 1'b1);
        fetch(UC_ADDR, 1'b0, 1'b1, 1'b0);
        fetch(UC_ADDR, 1'b0, 1'b1, 1'b0);
        fetch(UC_ADDR, 1'b0, 1'b0, 1'b0);
        fetch(UC_ADDR, 1'b0, 1'b0, 1'b1);
        fill_line(LINE_B);
        maintain(index_invalidate, LINE_B, 1'b0);
        fill_line(LINE_B);
        // stored tag on the cleared set brings back the old line data
        maintain(index_invalidate, LINE_B, 1'b0);
        maintain(index_store_tag, LINE_B, 1'b1);
        fetch(LINE_B + 32'h20, 1'b1, 1'b0, 1'b0);
        fetch(LINE_B, 1'b1, 1'b0, 1'b0);
        fill_line(LINE_C);
        maintain(hit_invalidate, ALIAS_C, 1'b0);
        fetch(LINE_C + 32'h4, 1'b1, 1'b0, 1'b0);
        maintain(hit_invalidate, LINE_C + 32'h10, 1'b0);
        fill_line(LINE_C + 32'h10);
        // same set, different tags
        repeat (2) begin
            fill_line(LINE_E);
            fill_line(LINE_F);
        end
        idle_cycles(5);
        report_counts();
        if (data_errors + ar_errors + miss_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < 40 * fetch_count + 200) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d fetches issued", cycle_count, fetch_count);
        report_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
// axi read slave model, address-derived data with lfsr-driven arready and rvalid gaps
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem #(
    parameter icache_pkg::word_t DATA_KEY = 32'h5a5a5a5a,
    parameter logic [31:0]       SEED     = 32'h3aa1
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  icache_pkg::axi_ar_t ar,
    input  logic                arvalid,
    output logic                arready,
    output icache_pkg::axi_r_t  r,
    output logic                rvalid
);
    import icache_pkg::*;

    logic [31:0] lfsr;
    axi_ar_t     req;
    int          gap;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // two bits per gap, one step per bit
    task automatic draw_gap(output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            cycles = (cycles << 1) | int'(lfsr[31]);
            lfsr   = lfsr_step(lfsr);
        end
    endtask

    initial begin
        lfsr    = SEED;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge aclk);
            if (aresetn && arvalid) begin
                draw_gap(gap);
                repeat (gap) @(negedge aclk);
                arready = 1'b1;
                req     = ar;
                @(negedge aclk);
                arready = 1'b0;
                // one beat per word, data from the beat's byte address
                for (int beat = 0; beat <= int'(req.len); beat++) begin
                    draw_gap(gap);
                    repeat (gap) @(negedge aclk);
                    r.id   = req.id;
                    r.data = (req.addr + addr_t'(beat * 4)) ^ DATA_KEY;
                    r.resp = 2'b00;
                    r.last = (beat == int'(req.len));
                    rvalid = 1'b1;
                    @(negedge aclk);
                    rvalid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
// instruction cache top, controller with tag array and line data ram
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
    parameter int SET_COUNT = 64
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  icache_pkg::cpu_req_t cpu_req,
    input  logic                 bus_stall,
    output logic                 bus_streq,
    output icache_pkg::word_t    bus_rdata,
    input  icache_pkg::cop_req_t cop,
    output icache_pkg::axi_ar_t  ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  icache_pkg::axi_r_t   r,
    input  logic                 rvalid
);
    import icache_pkg::*;

    localparam int RAM_AW = $clog2(SET_COUNT) + WORD_SEL_W;

    logic              lookup_hit;
    tag_cmd_t          tag_cmd;
    logic              ram_wen;
    logic [RAM_AW-1:0] ram_waddr;
    word_t             ram_wdata;
    word_t             ram_rdata;

    icache_controller #(
        .SET_COUNT (SET_COUNT)
    ) i_icache_controller (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cpu_req    (cpu_req),
        .bus_stall  (bus_stall),
        .bus_streq  (bus_streq),
        .bus_rdata  (bus_rdata),
        .cop        (cop),
        .lookup_hit (lookup_hit),
        .tag_cmd    (tag_cmd),
        .ram_wen    (ram_wen),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid)
    );

    // cmd_hit only serves clear_if_match inside the array
    icache_tag_array #(
        .SET_COUNT (SET_COUNT)
    ) i_icache_tag_array (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .lookup_addr (cpu_req.addr),
        .lookup_hit  (lookup_hit),
        .tag_cmd     (tag_cmd),
        .cmd_hit     ()
    );

    icache_data_ram #(
        .SET_COUNT (SET_COUNT)
    ) i_icache_data_ram (
        .aclk      (aclk),
        .ram_wen   (ram_wen),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .raddr     (cpu_req.addr),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- icache_controller.sv
// miss detection, fill and uncached fsm, axi read requests, uncached word buffer, read data select
`timescale 1ns/1ns
`default_nettype none

module icache_controller #(
    parameter int SET_COUNT = 64
) (
    input  logic                                                 aclk,
    input  logic                                                 aresetn,
    input  icache_pkg::cpu_req_t                                 cpu_req,
    input  logic                                                 bus_stall,
    output logic                                                 bus_streq,
    output icache_pkg::word_t                                    bus_rdata,
    input  icache_pkg::cop_req_t                                 cop,
    input  logic                                                 lookup_hit,
    output icache_pkg::tag_cmd_t                                 tag_cmd,
    output logic                                                 ram_wen,
    output logic [$clog2(SET_COUNT)+icache_pkg::WORD_SEL_W-1:0] ram_waddr,
    output icache_pkg::word_t                                    ram_wdata,
    input  icache_pkg::word_t                                    ram_rdata,
    output icache_pkg::axi_ar_t                                  ar,
    output logic                                                 arvalid,
    input  logic                                                 arready,
    input  icache_pkg::axi_r_t                                   r,
    input  logic                                                 rvalid
);
    import icache_pkg::*;

    localparam int INDEX_W = $clog2(SET_COUNT);
    localparam int TAG_W   = 32 - INDEX_W - LINE_BYTE_W;

    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] beat_t;

    ctrl_state_e state;
    beat_t       beat_cnt;
    word_t       uc_buf;
    logic        uc_valid;
    logic        uc_hit;
    logic        cached_miss;
    logic        uc_miss;
    addr_t       line_addr;
    index_t      fill_index;

    // held word belongs to the last uncached request address
    assign uc_hit = uc_valid && (ar.addr == cpu_req.addr);

    assign cached_miss = cpu_req.en && cpu_req.cached && !lookup_hit;
    assign uc_miss     = cpu_req.en && !cpu_req.cached && !uc_hit;
    assign bus_streq   = cached_miss || uc_miss;

    assign bus_rdata = cpu_req.cached ? ram_rdata : uc_buf;

    assign line_addr  = {cpu_req.addr[31:LINE_BYTE_W], {LINE_BYTE_W{1'b0}}};
    assign fill_index = ar.addr[LINE_BYTE_W +: INDEX_W];

    // single command port into the tag array
    always_comb begin
        tag_cmd.op    = none;
        tag_cmd.addr  = cpu_req.addr;
        tag_cmd.tag   = word_t'(cpu_req.addr[31 -: TAG_W]);
        tag_cmd.valid = 1'b0;
        case (state)
            idle: begin
                if (cop.en) begin
                    tag_cmd.addr  = cop.addr;
                    tag_cmd.tag   = cop.tag;
                    tag_cmd.valid = cop.valid;
                    case (cop.op)
                        index_invalidate: tag_cmd.op = clear_valid;
                        index_store_tag:  tag_cmd.op = write_tag;
                        hit_invalidate:   tag_cmd.op = clear_if_match;
                        default:          tag_cmd.op = none;
                    endcase
                end else if (cached_miss) begin
                    // claim the set, valid stays low until the fill ends
                    tag_cmd.op = write_tag;
                end
            end
            fill_end: begin
                tag_cmd.op   = set_valid;
                tag_cmd.addr = ar.addr;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= idle;
            arvalid  <= 1'b0;
            beat_cnt <= '0;
            uc_valid <= 1'b0;
            ram_wen  <= 1'b0;
        end else begin
            ram_wen <= 1'b0;
            case (state)
                idle: begin
                    beat_cnt <= '0;
                    if (!cop.en && cached_miss) begin
                        arvalid <= 1'b1;
                        state   <= fill_addr;
                    end else if (!cop.en && uc_miss) begin
                        arvalid <= 1'b1;
                        state   <= uc_addr;
                    end
                end
                fill_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= fill_data;
                    end
                end
                fill_data: begin
                    if (rvalid) begin
                        ram_wen  <= 1'b1;
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state <= fill_end;
                        end
                    end
                end
                fill_end: begin
                    state <= idle;
                end
                uc_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= uc_data;
                    end
                end
                uc_data: begin
                    if (rvalid) begin
                        uc_valid <= 1'b1;
                        state    <= uc_hold;
                    end
                end
                uc_hold: begin
                    // released once the fetch stage takes the word
                    if (cpu_req.en && uc_hit && !bus_stall) begin
                        uc_valid <= 1'b0;
                        state    <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == idle && !cop.en) begin
            if (cached_miss) begin
                ar.id   <= FILL_ID;
                ar.addr <= line_addr;
                ar.len  <= axi_len_t'(LINE_WORDS - 1);
            end else if (uc_miss) begin
                ar.id   <= UNCACHED_ID;
                ar.addr <= cpu_req.addr;
                ar.len  <= '0;
            end
        end
        if (state == fill_data && rvalid) begin
            ram_waddr <= {fill_index, beat_cnt};
            ram_wdata <= r.data;
        end
        if (state == uc_data && rvalid) begin
            uc_buf <= r.data;
        end
    end

    a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar changed or arvalid dropped before handshake");

    a_cop_in_idle: assert property (@(posedge aclk) disable iff (!aresetn)
        cop.en |-> state == idle)
        else $error("maintenance op outside idle, state %s", state.name());

    a_rlast_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && (state inside {fill_data, uc_data}) |-> r.last == (beat_cnt == beat_t'(ar.len)))
        else $error("rlast mismatch at beat %0d, len %0d", beat_cnt, ar.len);

endmodule

`default_nettype wire

//--- icache_tag_array.sv
// tag and valid storage, fetch and command hit compares, tag command execution
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array #(
    parameter int SET_COUNT = 64
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  icache_pkg::addr_t    lookup_addr,
    output logic                 lookup_hit,
    input  icache_pkg::tag_cmd_t tag_cmd,
    output logic                 cmd_hit
);
    import icache_pkg::*;

    localparam int INDEX_W = $clog2(SET_COUNT);
    localparam int TAG_W   = 32 - INDEX_W - LINE_BYTE_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    tag_t                 tags [SET_COUNT];
    logic [SET_COUNT-1:0] valid_bits;

    index_t lookup_index;
    tag_t   lookup_tag;
    index_t cmd_index;
    tag_t   cmd_tag;

    assign lookup_index = lookup_addr[LINE_BYTE_W +: INDEX_W];
    assign lookup_tag   = lookup_addr[31 -: TAG_W];
    assign cmd_index    = tag_cmd.addr[LINE_BYTE_W +: INDEX_W];
    assign cmd_tag      = tag_cmd.addr[31 -: TAG_W];

    assign lookup_hit = valid_bits[lookup_index] && (tags[lookup_index] == lookup_tag);
    assign cmd_hit    = valid_bits[cmd_index] && (tags[cmd_index] == cmd_tag);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_bits <= '0;
        end else begin
            case (tag_cmd.op)
                write_tag: begin
                    valid_bits[cmd_index] <= tag_cmd.valid;
                end
                set_valid: begin
                    valid_bits[cmd_index] <= 1'b1;
                end
                clear_valid: begin
                    valid_bits[cmd_index] <= 1'b0;
                end
                clear_if_match: begin
                    if (cmd_hit) begin
                        valid_bits[cmd_index] <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // tag field of the command is right aligned
    always_ff @(posedge aclk) begin
        if (tag_cmd.op == write_tag) begin
            tags[cmd_index] <= tag_cmd.tag[TAG_W-1:0];
        end
    end

    a_cmd_op_legal: assert property (@(posedge aclk) disable iff (!aresetn)
        tag_cmd.op inside {none, write_tag, set_valid, clear_valid, clear_if_match})
        else $error("illegal tag command op %0d", tag_cmd.op);

endmodule

`default_nettype wire

//--- icache_data_ram.sv
// line data storage, clocked write port and combinational read port
`timescale 1ns/1ns
`default_nettype none

module icache_data_ram #(
    parameter int SET_COUNT = 64
) (
    input  logic                                                 aclk,
    input  logic                                                 ram_wen,
    input  logic [$clog2(SET_COUNT)+icache_pkg::WORD_SEL_W-1:0] ram_waddr,
    input  icache_pkg::word_t                                    ram_wdata,
    input  icache_pkg::addr_t                                    raddr,
    output icache_pkg::word_t                                    ram_rdata
);
    import icache_pkg::*;

    localparam int RAM_AW    = $clog2(SET_COUNT) + WORD_SEL_W;
    localparam int RAM_DEPTH = SET_COUNT * LINE_WORDS;

    typedef logic [RAM_AW-1:0] ram_addr_t;

    word_t     mem [RAM_DEPTH];
    ram_addr_t ram_raddr;

    // index and word offset, byte offset dropped
    assign ram_raddr = raddr[RAM_AW+1:2];

    always_ff @(posedge aclk) begin
        if (ram_wen) begin
            mem[ram_waddr] <= ram_wdata;
        end
    end

    assign ram_rdata = mem[ram_raddr];

endmodule

`default_nettype wire

//--- icache_pkg.sv
// shared widths, axi ids, cache op and tag command encodings, request structs, controller states
`default_nettype none

package icache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  axi_len_t;

    localparam axi_id_t FILL_ID     = 4'd3;
    localparam axi_id_t UNCACHED_ID = 4'd2;

    // line geometry, 16 words of 4 bytes
    localparam int LINE_WORDS  = 16;
    localparam int WORD_SEL_W  = $clog2(LINE_WORDS);
    localparam int LINE_BYTE_W = WORD_SEL_W + 2;

    typedef enum logic [1:0] {
        nop,
        index_invalidate,
        index_store_tag,
        hit_invalidate
    } cache_op_e;

    typedef enum logic [2:0] {
        none,
        write_tag,
        set_valid,
        clear_valid,
        clear_if_match
    } tag_op_e;

    typedef enum logic [2:0] {
        idle,
        fill_addr,
        fill_data,
        fill_end,
        uc_addr,
        uc_data,
        uc_hold
    } ctrl_state_e;

    typedef struct packed {
        logic  en;
        addr_t addr;
        logic  cached;
    } cpu_req_t;

    // tag is right aligned in the word
    typedef struct packed {
        logic      en;
        cache_op_e op;
        addr_t     addr;
        word_t     tag;
        logic      valid;
    } cop_req_t;

    typedef struct packed {
        tag_op_e op;
        addr_t   addr;
        word_t   tag;
        logic    valid;
    } tag_cmd_t;

    typedef struct packed {
        axi_id_t  id;
        addr_t    addr;
        axi_len_t len;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t    id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

endpackage

`default_nettype wire
